// File: jstkPkg.sv
package jstkPkg;

    // ----------------------------------------
    // Axis sampling and thresholds
    // ----------------------------------------
    localparam int axisWidth = 10;                              // 10-bit joystick ADC
    localparam logic [axisWidth-1:0] lowThresh  = axisWidth'(350);  // At or below is negative
    localparam logic [axisWidth-1:0] highThresh = axisWidth'(650);  // At or above is positive

    // ----------------------------------------
    // Frame format
    // ----------------------------------------
    localparam int frameBytes = 5;          // X lo, X hi, Y lo, Y hi, buttons
    localparam logic [7:0] cmdBase = 8'h80; // LED bits go in [1:0]

    // Direction of one axis
    typedef enum logic [1:0] {
        dirCentre = 2'd0,
        dirNeg    = 2'd1,   // Left or up
        dirPos    = 2'd2    // Right or down
    } axisDir;

    // Nine-valued joystick mode, clockwise from left
    typedef enum logic [3:0] {
        modeIdle      = 4'd0,
        modeLeft      = 4'd1,
        modeLeftUp    = 4'd2,
        modeUp        = 4'd3,
        modeRightUp   = 4'd4,
        modeRight     = 4'd5,
        modeRightDown = 4'd6,
        modeDown      = 4'd7,
        modeLeftDown  = 4'd8
    } jstkMode;

    // Received frame, byte 0 arrives first and sits in the low bits
    typedef union packed {
        logic [frameBytes-1:0][7:0] bytes;  // Arrival order view
        struct packed {
            logic [7:0] buttons;    // Byte 4
            logic [7:0] yHigh;      // Byte 3, bits 1..0 used
            logic [7:0] yLow;       // Byte 2
            logic [7:0] xHigh;      // Byte 1, bits 1..0 used
            logic [7:0] xLow;       // Byte 0
        } fields;
    } jstkFrame;

endpackage

// File: spiByteIf.sv
// One-byte handshake between frame sequencer and SPI shifter
interface spiByteIf;

    logic       start;      // One-cycle request, only while busy low
    logic [7:0] txByte;     // Valid with start
    logic [7:0] rxByte;     // Complete when busy falls
    logic       busy;       // High for the whole transfer

    // Frame controller side
    modport ctrl (
        output start,
        output txByte,
        input  rxByte,
        input  busy
    );

    // Byte engine side
    modport engine (
        input  start,
        input  txByte,
        output rxByte,
        output busy
    );

endinterface

// File: spiByteEngine.sv
module spiByteEngine #(
    parameter int sclkHalf = 2      // CLK cycles per SCLK half period
) (
    input  logic     CLK,
    input  logic     RST,
    spiByteIf.engine bus,
    input  logic     MISO,
    output logic     SCLK,
    output logic     MOSI
);

    localparam int halfW = $clog2(sclkHalf + 1);

    // Engine states
    localparam logic [1:0] stIdle  = 2'd0;
    localparam logic [1:0] stShift = 2'd1;  // SCLK toggling
    localparam logic [1:0] stDone  = 2'd2;  // Trailing cycle before busy drops

    logic [1:0]       state;
    logic [halfW-1:0] halfCnt;      // Position inside current SCLK half
    logic [3:0]       riseCnt;      // Rising edges so far
    logic [7:0]       wSR;          // Write shift register, MSB on MOSI
    logic [7:0]       rSR;          // Read shift register
    logic             sclkReg;
    logic             halfTick;     // Last cycle of a half period

    assign halfTick   = (halfCnt == halfW'(sclkHalf - 1));
    assign SCLK       = sclkReg;
    assign MOSI       = wSR[7];
    assign bus.rxByte = rSR;

    // ----------------------------------------
    // Control and write path
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (RST) begin
            state    <= stIdle;
            bus.busy <= 1'b0;
            sclkReg  <= 1'b0;               // SCLK idles low
            halfCnt  <= '0;
            riseCnt  <= '0;
            wSR      <= '0;                 // MOSI low out of reset
        end else begin
            case (state)
                stIdle: begin
                    if (bus.start) begin
                        state    <= stShift;
                        bus.busy <= 1'b1;
                        wSR      <= bus.txByte; // MSB visible before first rise
                        halfCnt  <= '0;
                        riseCnt  <= '0;
                    end
                end

                stShift: begin
                    if (halfTick) begin
                        halfCnt <= '0;
                        sclkReg <= ~sclkReg;
                        if (!sclkReg) begin
                            riseCnt <= riseCnt + 4'd1;  // Rising edge
                        end else begin
                            // Falling edge, next bit onto MOSI
                            wSR <= {wSR[6:0], 1'b0};
                            if (riseCnt == 4'd8) begin
                                state <= stDone;
                            end
                        end
                    end else begin
                        halfCnt <= halfCnt + 1'b1;
                    end
                end

                stDone: begin
                    state    <= stIdle;
                    bus.busy <= 1'b0;       // rxByte already complete
                end

                default: state <= stIdle;
            endcase
        end
    end

    // Read path, MISO taken as SCLK goes high
    always_ff @(posedge CLK) begin
        if (state == stShift && halfTick && !sclkReg) begin
            rSR <= {rSR[6:0], MISO};        // MSB first
        end
    end

endmodule

// File: jstkFrameCtrl.sv
module jstkFrameCtrl import jstkPkg::*; #(
    parameter int pollPeriod = 400      // CLK cycles between polls
) (
    input  logic       CLK,
    input  logic       RST,
    spiByteIf.ctrl     bus,
    input  logic [1:0] ledCmd,
    output logic       SS,
    output jstkFrame   frame,
    output logic       frameValid
);

    localparam int pollW = $clog2(pollPeriod);
    localparam int idxW  = $clog2(frameBytes);
    localparam logic [idxW-1:0] lastIdx = idxW'(frameBytes - 1);

    // Sequencer states
    localparam logic [2:0] stIdle     = 3'd0;
    localparam logic [2:0] stIssue    = 3'd1;   // start pulse
    localparam logic [2:0] stWaitBusy = 3'd2;
    localparam logic [2:0] stStore    = 3'd3;   // Capture rxByte
    localparam logic [2:0] stDone     = 3'd4;   // Publish frame

    logic [2:0]       state;
    logic [pollW-1:0] pollCnt;
    logic             pollTick;
    logic [idxW-1:0]  byteIdx;      // Arrival index of current byte
    jstkFrame         shadow;       // Frame being assembled

    // ----------------------------------------
    // Poll timer, free running
    // ----------------------------------------
    assign pollTick = (pollCnt == pollW'(pollPeriod - 1));

    always_ff @(posedge CLK) begin
        if (RST) begin
            pollCnt <= '0;
        end else if (pollTick) begin
            pollCnt <= '0;
        end else begin
            pollCnt <= pollCnt + 1'b1;
        end
    end

    // Same command byte for every position in the frame
    assign bus.start  = (state == stIssue);
    assign bus.txByte = cmdBase | {6'b000000, ledCmd};

    // ----------------------------------------
    // Frame sequencer
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (RST) begin
            state      <= stIdle;
            SS         <= 1'b1;             // Slave deselected
            frameValid <= 1'b0;
            byteIdx    <= '0;
        end else begin
            frameValid <= 1'b0;             // Pulse by default low
            case (state)
                stIdle: begin
                    if (pollTick) begin     // Ticks elsewhere are dropped
                        state   <= stIssue;
                        SS      <= 1'b0;
                        byteIdx <= '0;
                    end
                end
                stIssue:    state <= stWaitBusy; // busy high from next cycle
                stWaitBusy: begin
                    if (!bus.busy) begin
                        state <= stStore;
                    end
                end
                stStore: begin
                    if (byteIdx == lastIdx) begin
                        state <= stDone;
                    end else begin
                        byteIdx <= byteIdx + 1'b1;
                        state   <= stIssue;
                    end
                end
                stDone: begin
                    SS         <= 1'b1;     // Rises with frameValid
                    frameValid <= 1'b1;
                    state      <= stIdle;
                end
                default: state <= stIdle;
            endcase
        end
    end

    // Byte capture and publish
    always_ff @(posedge CLK) begin
        if (state == stStore) begin
            shadow.bytes[byteIdx] <= bus.rxByte;
        end
        if (state == stDone) begin
            frame <= shadow;                // Held until next frameValid
        end
    end

endmodule

// File: axisClassifier.sv
module axisClassifier import jstkPkg::*; (
    input  logic                 CLK,
    input  logic                 RST,
    input  logic [axisWidth-1:0] sample,
    input  logic                 sampleValid,
    output axisDir               dir,
    output logic                 dirChanged
);

    axisDir newDir;     // Direction of incoming sample

    // Threshold rule, both bounds inclusive
    always_comb begin
        if (sample <= lowThresh) begin
            newDir = dirNeg;
        end else if (sample >= highThresh) begin
            newDir = dirPos;
        end else begin
            newDir = dirCentre;         // Dead zone
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            dir        <= dirCentre;
            dirChanged <= 1'b0;
        end else begin
            dirChanged <= 1'b0;
            if (sampleValid) begin
                dir        <= newDir;
                dirChanged <= (newDir != dir);  // Compare with previous frame
            end
        end
    end

endmodule

// File: modeEncoder.sv
module modeEncoder import jstkPkg::*; (
    input  logic    CLK,
    input  logic    RST,
    input  axisDir  xDir,
    input  axisDir  yDir,
    input  logic    xChanged,
    input  logic    yChanged,
    output jstkMode mode,
    output logic    modeStrobe
);

    jstkMode nextMode;

    // Direction pair to mode, Y negative is up
    always_comb begin
        case ({xDir, yDir})
            {dirCentre, dirCentre}: nextMode = modeIdle;
            {dirNeg,    dirCentre}: nextMode = modeLeft;
            {dirNeg,    dirNeg}:    nextMode = modeLeftUp;
            {dirCentre, dirNeg}:    nextMode = modeUp;
            {dirPos,    dirNeg}:    nextMode = modeRightUp;
            {dirPos,    dirCentre}: nextMode = modeRight;
            {dirPos,    dirPos}:    nextMode = modeRightDown;
            {dirCentre, dirPos}:    nextMode = modeDown;
            {dirNeg,    dirPos}:    nextMode = modeLeftDown;
            default:                nextMode = modeIdle;    // Unused code 3
        endcase
    end

    // Update only on a direction change
    always_ff @(posedge CLK) begin
        if (RST) begin
            mode       <= modeIdle;
            modeStrobe <= 1'b0;
        end else begin
            modeStrobe <= 1'b0;
            if (xChanged || yChanged) begin
                mode       <= nextMode;
                modeStrobe <= 1'b1;
            end
        end
    end

endmodule

// File: joystickTop.sv
module joystickTop import jstkPkg::*; #(
    parameter int sclkHalf   = 750,         // About 66 kHz SCLK at 100 MHz
    parameter int pollPeriod = 20000000     // 5 Hz polling at 100 MHz
) (
    input  logic       CLK,
    input  logic       RST,
    input  logic       MISO,
    input  logic [1:0] ledCmd,
    output logic       SS,
    output logic       SCLK,
    output logic       MOSI,
    output logic [3:0] mode,
    output logic       modeStrobe,
    output logic [2:0] buttons
);

    spiByteIf byteBus ();

    jstkFrame             frame;
    logic                 frameValid;
    logic [axisWidth-1:0] axisSample [2];   // 0 is X, 1 is Y
    axisDir               axisDirs [2];
    logic                 axisChanged [2];

    spiByteEngine #(.sclkHalf(sclkHalf)) engineI (
        .CLK(CLK), .RST(RST), .bus(byteBus.engine),
        .MISO(MISO), .SCLK(SCLK), .MOSI(MOSI)
    );

    jstkFrameCtrl #(.pollPeriod(pollPeriod)) frameCtrlI (
        .CLK(CLK), .RST(RST), .bus(byteBus.ctrl), .ledCmd(ledCmd),
        .SS(SS), .frame(frame), .frameValid(frameValid)
    );

    // 10-bit axis values from low byte plus two high bits
    assign axisSample[0] = {frame.fields.xHigh[1:0], frame.fields.xLow};
    assign axisSample[1] = {frame.fields.yHigh[1:0], frame.fields.yLow};

    for (genvar a = 0; a < 2; a++) begin : genAxis
        axisClassifier axisI (
            .CLK(CLK), .RST(RST), .sample(axisSample[a]), .sampleValid(frameValid),
            .dir(axisDirs[a]), .dirChanged(axisChanged[a])
        );
    end

    modeEncoder encoderI (
        .CLK(CLK), .RST(RST), .xDir(axisDirs[0]), .yDir(axisDirs[1]),
        .xChanged(axisChanged[0]), .yChanged(axisChanged[1]),
        .mode(mode), .modeStrobe(modeStrobe)
    );

    // Button latch, one cycle behind frameValid
    always_ff @(posedge CLK) begin
        if (RST) begin
            buttons <= '0;
        end else if (frameValid) begin
            buttons <= frame.fields.buttons[2:0];
        end
    end

endmodule

// File: tbJoystick_asserts.sv
module tbJoystickAsserts #(
    parameter int sclkHalf = 2
) (
    input logic CLK,
    input logic RST,
    input logic start,
    input logic busy,
    input logic SCLK
);

    timeunit 1ns;
    timeprecision 100ps;

    // Sampled busy cycles, one less than start to busy fall
    localparam int busyLen = 16 * sclkHalf + 1;

    int busyCnt;    // Consecutive busy samples

    always_ff @(posedge CLK) begin
        if (RST || !busy) begin
            busyCnt <= 0;
        end else begin
            busyCnt <= busyCnt + 1;
        end
    end

    sclkIdleLow: assert property (@(posedge CLK) disable iff (RST) !busy |-> !SCLK)
        else $error("SCLK high while the byte engine is idle");

    noStartWhileBusy: assert property (@(posedge CLK) disable iff (RST) start |-> !busy)
        else $error("start raised while the byte engine is busy");

    busyLength: assert property (@(posedge CLK) disable iff (RST)
        $fell(busy) |-> busyCnt == busyLen)
        else $error("busy high for %0d cycles instead of %0d", busyCnt, busyLen);

endmodule

bind spiByteEngine tbJoystickAsserts #(.sclkHalf(sclkHalf)) assertsI (
    .CLK(CLK), .RST(RST), .start(bus.start), .busy(bus.busy), .SCLK(SCLK)
);

// File: tbJoystick.sv
module tbJoystick;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int sclkHalf   = 2;
    localparam int pollPeriod = 400;

    // DUT ports
    logic       CLK = 1'b0;
    logic       RST;
    logic       MISO;
    logic [1:0] ledCmd;
    logic       SS;
    logic       SCLK;
    logic       MOSI;
    logic [3:0] mode;
    logic       modeStrobe;
    logic [2:0] buttons;

    // Test table from file
    int tX[$];
    int tY[$];
    int tBtn[$];
    int tLed[$];
    int tMode[$];
    int tStrobe[$];

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycleLimit = 0;   // Zero until tests are loaded
    logic [31:0] lfsrState = 32'h2e7d;

    // SPI slave model state
    logic [7:0]  txBytes [5];           // Arrival order
    logic [39:0] misoSR = '0;           // Bit 39 is on MISO
    logic [7:0]  mosiSR = '0;
    logic [7:0]  capBytes [$];          // Bytes seen on MOSI this frame
    int          rxBits = 0;
    logic        prevSs = 1'b1;
    logic        prevSclk = 1'b0;

    assign MISO = misoSR[39];

    always #2 CLK = ~CLK;               // 4 ns period

    joystickTop #(.sclkHalf(sclkHalf), .pollPeriod(pollPeriod)) dut_i (
        .CLK(CLK), .RST(RST), .MISO(MISO), .ledCmd(ledCmd),
        .SS(SS), .SCLK(SCLK), .MOSI(MOSI),
        .mode(mode), .modeStrobe(modeStrobe), .buttons(buttons)
    );

    // ----------------------------------------
    // SPI slave model on falling CLK
    // ----------------------------------------
    always @(negedge CLK) begin
        if (prevSs && !SS) begin        // Frame start puts MSB of byte 0 out
            misoSR = {txBytes[0], txBytes[1], txBytes[2], txBytes[3], txBytes[4]};
            rxBits = 0;
            capBytes.delete();
        end else if (!SS) begin
            if (!prevSclk && SCLK) begin
                mosiSR = {mosiSR[6:0], MOSI};   // Rising edge capture
                rxBits++;
                if (rxBits == 8) begin
                    capBytes.push_back(mosiSR);
                    rxBits = 0;
                end
            end else if (prevSclk && !SCLK) begin
                misoSR = misoSR << 1;   // Next bit after falling edge
            end
        end
        prevSs   = SS;
        prevSclk = SCLK;
    end

    // Run limit
    always @(posedge CLK) begin
        cycles++;
        if (cycleLimit != 0 && cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles, the DUT stopped producing frames", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end else begin
            return s >> 1;
        end
    endfunction

    task automatic takeBits(input int n, output logic [7:0] bits);
        int k;
        bits = '0;
        for (k = 0; k < n; k++) begin
            bits      = {bits[6:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic checkValue(input string what, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("** Error at %0.1f ns: %s is %0d, expected %0d",
                     $realtime, what, got, expected);
        end
    endtask

    task automatic loadTests(output bit ok);
        int    fd;
        int    n;
        int    v [6];
        string line;
        ok = 1'b0;
        fd = $fopen("jstk_tests.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %d %d %d %d %d",
                                v[0], v[1], v[2], v[3], v[4], v[5]);
                    if (n == 6) begin
                        tX.push_back(v[0]);
                        tY.push_back(v[1]);
                        tBtn.push_back(v[2]);
                        tLed.push_back(v[3]);
                        tMode.push_back(v[4]);
                        tStrobe.push_back(v[5]);
                    end
                end
            end
            $fclose(fd);
            ok = (tX.size() > 0);
        end
    endtask

    task automatic applyReset();
        RST = 1'b1;
        repeat (5) @(negedge CLK);
        RST = 1'b0;
        @(negedge CLK);
        checkValue("SS after reset", int'(SS), 1);
    endtask

    // Strobe must stay low while idle between frames
    task automatic waitFrameStart(input bit afterReset);
        while (SS === 1'b1) begin
            if (afterReset) begin
                checkValue("SCLK before first frame", int'(SCLK), 0);
                checkValue("mode before first frame", int'(mode), 0);
                checkValue("buttons before first frame", int'(buttons), 0);
            end
            checkValue("modeStrobe between frames", int'(modeStrobe), 0);
            @(negedge CLK);
        end
    endtask

    // ----------------------------------------
    // One frame per test line
    // ----------------------------------------
    task automatic runTest(input int i);
        logic [9:0] xv;
        logic [9:0] yv;
        logic [7:0] pad;
        logic [7:0] expCmd;
        xv     = 10'(tX[i]);
        yv     = 10'(tY[i]);
        ledCmd = 2'(tLed[i]);
        expCmd = 8'h80 + 8'(tLed[i]);   // 0x80 plus the LED command value
        // Unused high bits get noise
        txBytes[0] = xv[7:0];
        takeBits(6, pad);
        txBytes[1] = {pad[5:0], xv[9:8]};
        txBytes[2] = yv[7:0];
        takeBits(6, pad);
        txBytes[3] = {pad[5:0], yv[9:8]};
        takeBits(5, pad);
        txBytes[4] = {pad[4:0], 3'(tBtn[i])};

        waitFrameStart(i == 0);
        while (SS !== 1'b1) @(negedge CLK);
        checkValue($sformatf("test %0d modeStrobe at SS rise", i), int'(modeStrobe), 0);
        @(negedge CLK);
        checkValue($sformatf("test %0d buttons", i), int'(buttons), tBtn[i]);
        checkValue($sformatf("test %0d early modeStrobe", i), int'(modeStrobe), 0);
        @(negedge CLK);                 // Two cycles after SS rise
        checkValue($sformatf("test %0d modeStrobe", i), int'(modeStrobe), tStrobe[i]);
        checkValue($sformatf("test %0d mode", i), int'(mode), tMode[i]);
        checkValue($sformatf("test %0d bytes in frame", i), capBytes.size(), 5);
        checkValue($sformatf("test %0d leftover MOSI bits", i), rxBits, 0);
        foreach (capBytes[k]) begin
            checkValue($sformatf("test %0d MOSI byte %0d", i, k),
                       int'(capBytes[k]), int'(expCmd));
        end
        @(negedge CLK);
    endtask

    initial begin
        bit loadOk;
        RST    = 1'b1;
        ledCmd = 2'b00;
        loadTests(loadOk);
        if (!loadOk) begin
            $display("Could not read any test from jstk_tests.txt");
            $display("Errors found");
            $finish;
        end else begin
            cycleLimit = (tX.size() + 2) * pollPeriod * 2;
            applyReset();
            for (int i = 0; i < tX.size(); i++) begin
                runTest(i);
            end
            $display("Checks run %0d, errors %0d", checks, errors);
            if (errors == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

endmodule

// File: jstk_tests.txt
# One test per line and all columns decimal
# xValue yValue buttons ledCmd expectedMode expectedStrobe
512 512 0 0 0 0
350 512 1 1 1 1
351 512 2 2 0 1
649 649 3 3 0 0
650 649 4 0 5 1
1023 600 5 1 5 0
650 350 6 2 4 1
700 0 7 3 4 0
500 100 0 0 3 1
0 0 1 1 2 1
200 900 2 2 8 1
512 1023 3 3 7 1
900 650 4 0 6 1
512 512 5 1 0 1
351 649 7 2 0 0

// File: vlog.f
jstkPkg.sv
spiByteIf.sv
spiByteEngine.sv
jstkFrameCtrl.sv
axisClassifier.sv
modeEncoder.sv
joystickTop.sv
tbJoystick_asserts.sv
tbJoystick.sv

// File: run.sh
#!/bin/sh
# Build and run the joystick testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f vlog.f --top-module tbJoystick -o simJoystick
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simJoystick)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1
